//--- common/pad_pkg.sv
// Pad word layout and serial-controller codes; unknown type codes use the default select button
package pad_pkg;

	////////////////////////////////////////
	// Word types
	////////////////////////////////////////

	// Core joypad word, bits 11 to 15 unused, bit 10 is rewind
	typedef logic [15:0] pad_word_t;

	// Serial-controller button vector, index is HID usage minus one
	typedef logic [31:0] llapi_buttons_t;

	// Serial-controller type code as reported by the port
	typedef logic [7:0] llapi_type_t;

	////////////////////////////////////////
	// Pad word bit positions
	////////////////////////////////////////

	localparam int PAD_BIT_RIGHT        = 0;
	localparam int PAD_BIT_LEFT         = 1;
	localparam int PAD_BIT_DOWN         = 2;
	localparam int PAD_BIT_UP           = 3;
	localparam int PAD_BIT_A            = 4;
	localparam int PAD_BIT_B            = 5;
	localparam int PAD_BIT_SELECT       = 6;
	localparam int PAD_BIT_START        = 7;
	localparam int PAD_BIT_FAST_FORWARD = 8;
	localparam int PAD_BIT_SAVESTATE    = 9;

	////////////////////////////////////////
	// Serial-controller button indices
	////////////////////////////////////////

	localparam int LLAPI_BTN_B          = 0;
	localparam int LLAPI_BTN_START      = 1;
	localparam int LLAPI_BTN_SELECT     = 4;
	localparam int LLAPI_BTN_A          = 5;
	// Controllers without a select button report it here
	localparam int LLAPI_BTN_SELECT_ALT = 6;
	localparam int LLAPI_BTN_UP         = 24;
	localparam int LLAPI_BTN_DOWN       = 25;
	localparam int LLAPI_BTN_LEFT       = 26;
	localparam int LLAPI_BTN_RIGHT      = 27;

	////////////////////////////////////////
	// Controller type codes
	////////////////////////////////////////

	// No controller, or one that cannot identify itself
	localparam llapi_type_t LLAPI_TYPE_NONE         = 8'd0;
	localparam llapi_type_t LLAPI_TYPE_INVALID      = 8'd255;
	// Families that lack a select button
	localparam llapi_type_t LLAPI_TYPE_ALT_SELECT_A = 8'd3;
	localparam llapi_type_t LLAPI_TYPE_ALT_SELECT_B = 8'd8;

	// Tap threshold in clk_sys cycles, 0.1 s at 32 MHz
	localparam int unsigned FF_TAP_CYCLES_DEFAULT = 32'd3_200_000;

endpackage

//--- filelist.f
+incdir+sim
common/pad_pkg.sv
pad_decode/pad_decode.sv
src/slot_assign.sv
src/fast_forward_latch.sv
src/pad_router.sv
sim/tb_pad_router.sv

//--- pad_decode/pad_decode.sv
// One serial port per instance; presence latches on the first button press and holds until reset
module pad_decode (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    llapi_select,
	input  logic                    llapi_en,
	input  pad_pkg::llapi_buttons_t llapi_buttons,
	input  pad_pkg::llapi_type_t    llapi_type,
	output pad_pkg::pad_word_t      pad,
	output logic                    present,
	output logic                    menu_combo
);

	// Set by any button activity, only reset clears it
	logic pressed;
	logic any_button;
	logic type_known;
	logic alt_select;
	pad_pkg::pad_word_t pad_map;

	assign any_button = |llapi_buttons;

	// Type 0 covers both "nothing plugged" and controllers without an id
	assign type_known = (llapi_type != pad_pkg::LLAPI_TYPE_NONE) &&
		(llapi_type != pad_pkg::LLAPI_TYPE_INVALID);

	assign alt_select = (llapi_type == pad_pkg::LLAPI_TYPE_ALT_SELECT_A) ||
		(llapi_type == pad_pkg::LLAPI_TYPE_ALT_SELECT_B);

	////////////////////////////////////////
	// Button mapping
	////////////////////////////////////////

	always_comb begin
		pad_map = '0;
		pad_map[pad_pkg::PAD_BIT_RIGHT] = llapi_buttons[pad_pkg::LLAPI_BTN_RIGHT];
		pad_map[pad_pkg::PAD_BIT_LEFT]  = llapi_buttons[pad_pkg::LLAPI_BTN_LEFT];
		pad_map[pad_pkg::PAD_BIT_DOWN]  = llapi_buttons[pad_pkg::LLAPI_BTN_DOWN];
		pad_map[pad_pkg::PAD_BIT_UP]    = llapi_buttons[pad_pkg::LLAPI_BTN_UP];
		pad_map[pad_pkg::PAD_BIT_A]     = llapi_buttons[pad_pkg::LLAPI_BTN_A];
		pad_map[pad_pkg::PAD_BIT_B]     = llapi_buttons[pad_pkg::LLAPI_BTN_B];
		pad_map[pad_pkg::PAD_BIT_START] = llapi_buttons[pad_pkg::LLAPI_BTN_START];
		// Alternate families put select on a spare face button
		if (alt_select) begin
			pad_map[pad_pkg::PAD_BIT_SELECT] = llapi_buttons[pad_pkg::LLAPI_BTN_SELECT_ALT];
		end else begin
			pad_map[pad_pkg::PAD_BIT_SELECT] = llapi_buttons[pad_pkg::LLAPI_BTN_SELECT];
		end
	end

	////////////////////////////////////////
	// Registered outputs
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pressed    <= 1'b0;
			present    <= 1'b0;
			pad        <= '0;
			menu_combo <= 1'b0;
		end else begin
			if (any_button) begin
				pressed <= 1'b1;
			end

			// Current press counts too, so presence follows its cause by one cycle
			present <= llapi_en && llapi_select &&
				(type_known || pressed || any_button);

			pad <= pad_map;

			// Down + A + B opens the on-screen menu
			menu_combo <= llapi_buttons[pad_pkg::LLAPI_BTN_DOWN] &
				llapi_buttons[pad_pkg::LLAPI_BTN_A] &
				llapi_buttons[pad_pkg::LLAPI_BTN_B];
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the pad_router testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wall -Wno-fatal \
	--top-module tb_pad_router \
	-f filelist.f \
	-o tb_pad_router

./obj_dir/tb_pad_router > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi

if ! grep -q "TEST PASS" "$LOG"; then
	exit 1
fi

exit 0

//--- sim/tb_pad_ref.svh
// Reference model for pad_router; included inside tb_pad_router, which must declare TAP_LIMIT first
`ifndef TB_PAD_REF_SVH
`define TB_PAD_REF_SVH

////////////////////////////////////////
// Per-port reference rules
////////////////////////////////////////

// A port counts once it has a known type or has ever shown a button
function automatic logic ref_present(input logic en, input logic sel, input logic [7:0] ty,
	input logic sticky, input logic [31:0] btn);
	return en && sel && ((ty != 8'd0 && ty != 8'd255) || sticky || (btn != 32'd0));
endfunction

function automatic logic [15:0] ref_map(input logic [31:0] btn, input logic [7:0] ty);
	logic [15:0] w;
	w = 16'h0000;
	w[0] = btn[27];
	w[1] = btn[26];
	w[2] = btn[25];
	w[3] = btn[24];
	w[4] = btn[5];
	w[5] = btn[0];
	// Types 3 and 8 report select on index 6
	w[6] = (ty == 8'd3 || ty == 8'd8) ? btn[6] : btn[4];
	w[7] = btn[1];
	return w;
endfunction

// Down, A and B together
function automatic logic ref_combo(input logic [31:0] btn);
	return btn[25] & btn[5] & btn[0];
endfunction

////////////////////////////////////////
// Slots and blanking
////////////////////////////////////////

// Result packed as {slot 3, slot 2, slot 1, slot 0}
function automatic logic [63:0] ref_slots(input logic [15:0] pa, input logic [15:0] pb,
	input logic pr_a, input logic pr_b, input logic [15:0] u0, input logic [15:0] u1,
	input logic [15:0] u2, input logic [15:0] u3);
	if (pr_a && pr_b) begin
		return {u1, u0, pb, pa};
	end
	if (pr_a || pr_b) begin
		return {u2, u1, (pr_b ? pb : u0), (pr_a ? pa : u0)};
	end
	return {u3, u2, u1, u0};
endfunction

function automatic logic [15:0] ref_blank(input logic [15:0] w);
	return w[9] ? 16'h0000 : w;
endfunction

////////////////////////////////////////
// Fast-forward model, one step per clock
////////////////////////////////////////

logic ffm_req_q;
logic ffm_latch;
logic ffm_tapped;
int   ffm_count;
logic ffm_out;

function automatic void ff_model_reset();
	ffm_req_q  = 1'b0;
	ffm_latch  = 1'b0;
	ffm_tapped = 1'b0;
	ffm_count  = 0;
	ffm_out    = 1'b0;
endfunction

function automatic void ff_model_step(input logic req);
	logic out_next;
	out_next = req | ffm_latch;
	if (req && !ffm_req_q) begin
		ffm_latch = 1'b0;
		ffm_count = 1;
	end else if (req && ffm_count < TAP_LIMIT) begin
		ffm_count = ffm_count + 1;
	end
	// Release of a short press toggles the latch
	if (!req && ffm_req_q) begin
		if (ffm_count < TAP_LIMIT && !ffm_tapped) begin
			ffm_latch  = 1'b1;
			ffm_tapped = 1'b1;
		end else begin
			ffm_tapped = 1'b0;
		end
	end
	ffm_req_q = req;
	ffm_out   = out_next;
endfunction

`endif

//--- sim/tb_pad_router.sv
// Runs pad_router with a 40-cycle tap threshold; expected values come from tb_pad_ref.svh
module tb_pad_router;

	localparam int TAP_LIMIT   = 40;
	localparam int N_MAP       = 200;
	localparam int N_PRESENCE  = 80;
	localparam int N_USB       = 150;
	localparam int N_FF        = 277;
	localparam int N_TOTAL     = N_MAP + N_PRESENCE + N_USB + N_FF + 10;

	logic                    clk_sys;
	logic                    reset;
	logic                    llapi_select;
	pad_pkg::llapi_buttons_t llapi_buttons_0;
	pad_pkg::llapi_type_t    llapi_type_0;
	logic                    llapi_en_0;
	pad_pkg::llapi_buttons_t llapi_buttons_1;
	pad_pkg::llapi_type_t    llapi_type_1;
	logic                    llapi_en_1;
	pad_pkg::pad_word_t      usb_pad_0;
	pad_pkg::pad_word_t      usb_pad_1;
	pad_pkg::pad_word_t      usb_pad_2;
	pad_pkg::pad_word_t      usb_pad_3;
	logic                    osd_status;
	logic                    ioctl_download;
	pad_pkg::pad_word_t      player_0;
	pad_pkg::pad_word_t      player_1;
	pad_pkg::pad_word_t      player_2;
	pad_pkg::pad_word_t      player_3;
	pad_pkg::pad_word_t      player_0_raw;
	logic                    osd_button;
	logic                    fast_forward;

	integer seed;
	int     error_count;
	int     check_count;
	logic   sticky_0;
	logic   sticky_1;
	logic [15:0] last_p0;

	// Expected results, one entry per driven vector
	logic [15:0] q_p0[$];
	logic [15:0] q_p1[$];
	logic [15:0] q_p2[$];
	logic [15:0] q_p3[$];
	logic [15:0] q_raw[$];
	logic        q_btn[$];
	logic        q_osd[$];
	logic        q_ioctl[$];

	`include "tb_pad_ref.svh"

	pad_router #(
		.tap_cycles (TAP_LIMIT)
	) pad_router_inst (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.llapi_select    (llapi_select),
		.llapi_buttons_0 (llapi_buttons_0),
		.llapi_type_0    (llapi_type_0),
		.llapi_en_0      (llapi_en_0),
		.llapi_buttons_1 (llapi_buttons_1),
		.llapi_type_1    (llapi_type_1),
		.llapi_en_1      (llapi_en_1),
		.usb_pad_0       (usb_pad_0),
		.usb_pad_1       (usb_pad_1),
		.usb_pad_2       (usb_pad_2),
		.usb_pad_3       (usb_pad_3),
		.osd_status      (osd_status),
		.ioctl_download  (ioctl_download),
		.player_0        (player_0),
		.player_1        (player_1),
		.player_2        (player_2),
		.player_3        (player_3),
		.player_0_raw    (player_0_raw),
		.osd_button      (osd_button),
		.fast_forward    (fast_forward)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("error %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic drive_vector(input logic sel, input logic en0, input logic [7:0] ty0,
		input logic [31:0] b0, input logic en1, input logic [7:0] ty1, input logic [31:0] b1,
		input logic [15:0] u0, input logic [15:0] u1, input logic [15:0] u2,
		input logic [15:0] u3, input logic osd, input logic dl);
		logic        pr0;
		logic        pr1;
		logic [63:0] slots;
		@(posedge clk_sys);
		llapi_select    <= sel;
		llapi_en_0      <= en0;
		llapi_type_0    <= ty0;
		llapi_buttons_0 <= b0;
		llapi_en_1      <= en1;
		llapi_type_1    <= ty1;
		llapi_buttons_1 <= b1;
		usb_pad_0       <= u0;
		usb_pad_1       <= u1;
		usb_pad_2       <= u2;
		usb_pad_3       <= u3;
		osd_status      <= osd;
		ioctl_download  <= dl;
		pr0 = ref_present(en0, sel, ty0, sticky_0, b0);
		pr1 = ref_present(en1, sel, ty1, sticky_1, b1);
		sticky_0 = sticky_0 | (b0 != 32'd0);
		sticky_1 = sticky_1 | (b1 != 32'd0);
		slots = ref_slots(ref_map(b0, ty0), ref_map(b1, ty1), pr0, pr1, u0, u1, u2, u3);
		q_raw.push_back(slots[15:0]);
		q_p0.push_back(ref_blank(slots[15:0]));
		q_p1.push_back(slots[31:16]);
		q_p2.push_back(slots[47:32]);
		q_p3.push_back(slots[63:48]);
		q_btn.push_back(ref_combo(b0) | ref_combo(b1));
		q_osd.push_back(osd);
		q_ioctl.push_back(dl);
	endtask

	function automatic logic [7:0] random_type();
		logic [7:0] ty;
		ty = $random(seed);
		case ($random(seed) & 3)
			0: ty = 8'd3;
			1: ty = 8'd8;
			default: begin
				if (ty == 8'd0 || ty == 8'd255) begin
					ty = 8'd1;
				end
			end
		endcase
		return ty;
	endfunction

	// USB word with fast-forward held for hold cycles, then gap cycles released
	task automatic press_ff(input int hold, input int gap, input logic osd, input logic dl);
		repeat (hold) drive_vector(0, 0, 0, 0, 0, 0, 0, 16'h0100, 0, 0, 0, osd, dl);
		repeat (gap) drive_vector(0, 0, 0, 0, 0, 0, 0, 16'h0000, 0, 0, 0, osd, dl);
	endtask

	initial begin
		seed            = 32'h405c_78ff;
		error_count     = 0;
		check_count     = 0;
		sticky_0        = 1'b0;
		sticky_1        = 1'b0;
		reset           = 1'b1;
		llapi_select    = 1'b0;
		llapi_buttons_0 = '0;
		llapi_type_0    = '0;
		llapi_en_0      = 1'b0;
		llapi_buttons_1 = '0;
		llapi_type_1    = '0;
		llapi_en_1      = 1'b0;
		usb_pad_0       = '0;
		usb_pad_1       = '0;
		usb_pad_2       = '0;
		usb_pad_3       = '0;
		osd_status      = 1'b0;
		ioctl_download  = 1'b0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;

		// Presence first, while both sticky flags are still clear
		repeat (10) drive_vector(1, 1, 0, 0, 1, 255, 0, $random(seed), $random(seed),
			$random(seed) & 16'hfdff, $random(seed), 0, 0);
		repeat (10) drive_vector(1, 1, 0, 0, 1, 255, 32'h0000_0020, $random(seed),
			$random(seed), $random(seed), $random(seed), 0, 0);
		// Port 1 now stays present with no buttons held
		repeat (10) drive_vector(1, 1, 0, 0, 1, 255, 0, $random(seed) & 16'hfdff,
			$random(seed), $random(seed), $random(seed), 0, 0);
		repeat (10) drive_vector(0, 1, 0, 0, 1, 255, 0, $random(seed), $random(seed),
			$random(seed), $random(seed), 0, 0);
		repeat (10) drive_vector(1, 1, 0, 0, 0, 255, 0, $random(seed), $random(seed),
			$random(seed), $random(seed), 0, 0);
		repeat (10) drive_vector(1, 1, 0, 32'h0100_0000, 1, 0, 0, $random(seed),
			$random(seed), $random(seed), $random(seed), 0, 0);
		repeat (10) drive_vector(1, 1, 255, 0, 1, 0, 0, $random(seed), $random(seed),
			$random(seed), $random(seed), 0, 0);
		// Port 1 disabled, so port 0 alone keeps slot 0 and USB 0 moves to slot 1
		repeat (10) drive_vector(1, 1, 0, $random(seed), 0, random_type(), $random(seed),
			$random(seed), $random(seed), $random(seed), $random(seed), 0, 0);

		// Mapping with random buttons on both ports
		repeat (N_MAP) drive_vector(1, 1, random_type(), $random(seed), 1, random_type(),
			$random(seed), $random(seed), $random(seed), $random(seed), $random(seed), 0, 0);

		// No serial pads, USB words carry random savestate and fast-forward bits
		repeat (N_USB) drive_vector(0, $random(seed), random_type(), $random(seed),
			$random(seed), random_type(), $random(seed), $random(seed), $random(seed),
			$random(seed), $random(seed), 0, 0);

		// Fast-forward taps and holds
		press_ff(0, 10, 0, 0);
		press_ff(10, 20, 0, 0);
		press_ff(15, 20, 0, 0);
		press_ff(TAP_LIMIT + 10, 20, 0, 0);
		press_ff(TAP_LIMIT - 1, 20, 0, 0);
		press_ff(5, 20, 0, 0);
		press_ff(8, 10, 1, 0);
		press_ff(8, 10, 0, 1);
		press_ff(5, 7, 0, 0);

		// Flush the pipeline
		repeat (10) drive_vector(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		// Second negedge, after the compare process has made its last check
		repeat (2) @(negedge clk_sys);
		$display("checks %0d errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	////////////////////////////////////////
	// Compare process
	////////////////////////////////////////

	initial begin
		ff_model_reset();
		last_p0 = 16'h0000;
		forever begin
			@(negedge clk_sys);
			// Front entry is two cycles old once three are in flight
			if (q_p0.size() == 3) begin
				ff_model_step(last_p0[8] && !q_osd[1] && !q_ioctl[1]);
				check_value("fast_forward", fast_forward, ffm_out);
				check_value("player_0", player_0, q_p0[0]);
				check_value("player_1", player_1, q_p1[0]);
				check_value("player_2", player_2, q_p2[0]);
				check_value("player_3", player_3, q_p3[0]);
				check_value("player_0_raw", player_0_raw, q_raw[0]);
				check_value("osd_button", osd_button, q_btn[0]);
				last_p0 = q_p0.pop_front();
				void'(q_p1.pop_front());
				void'(q_p2.pop_front());
				void'(q_p3.pop_front());
				void'(q_raw.pop_front());
				void'(q_btn.pop_front());
				void'(q_osd.pop_front());
				void'(q_ioctl.pop_front());
			end
		end
	end

	initial begin
		#((N_TOTAL + 200) * 10);
		$display("Simulation timed out before all vectors were checked");
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- src/fast_forward_latch.sv
// Tap latches fast-forward on release, next tap clears it; tap_cycles must suit the clk_sys rate
module fast_forward_latch #(
	parameter int unsigned tap_cycles = pad_pkg::FF_TAP_CYCLES_DEFAULT
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  pad_pkg::pad_word_t player_0,
	input  logic               osd_status,
	input  logic               ioctl_download,
	output logic               fast_forward
);

	logic        request;
	logic        request_q;
	logic        ff_latch;
	logic        was_tapped;
	logic [31:0] hold_count;
	logic        rise;
	logic        fall;

	// Ignored while the menu is open or a file is loading
	assign request = player_0[pad_pkg::PAD_BIT_FAST_FORWARD] &&
		!osd_status && !ioctl_download;

	assign rise = request && !request_q;
	assign fall = !request && request_q;

	////////////////////////////////////////
	// Hold timer and latch
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			request_q    <= 1'b0;
			ff_latch     <= 1'b0;
			was_tapped   <= 1'b0;
			hold_count   <= '0;
			fast_forward <= 1'b0;
		end else begin
			request_q <= request;

			// Saturate at the threshold, only below-or-not matters
			if (request && hold_count < tap_cycles) begin
				hold_count <= hold_count + 32'd1;
			end

			// Press cycle is part of the hold, so restart at one
			if (rise) begin
				ff_latch   <= 1'b0;
				hold_count <= 32'd1;
			end

			if (fall) begin
				was_tapped <= 1'b0;
				// Short press after a non-tap turns the latch on
				if (hold_count < tap_cycles && !was_tapped) begin
					was_tapped <= 1'b1;
					ff_latch   <= 1'b1;
				end
			end

			fast_forward <= request | ff_latch;
		end
	end

endmodule

//--- src/pad_router.sv
// Inputs sampled on clk_sys with no synchronizers; serial pad outputs must already be on this clock
module pad_router #(
	parameter int unsigned tap_cycles = pad_pkg::FF_TAP_CYCLES_DEFAULT
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    llapi_select,
	input  pad_pkg::llapi_buttons_t llapi_buttons_0,
	input  pad_pkg::llapi_type_t    llapi_type_0,
	input  logic                    llapi_en_0,
	input  pad_pkg::llapi_buttons_t llapi_buttons_1,
	input  pad_pkg::llapi_type_t    llapi_type_1,
	input  logic                    llapi_en_1,
	input  pad_pkg::pad_word_t      usb_pad_0,
	input  pad_pkg::pad_word_t      usb_pad_1,
	input  pad_pkg::pad_word_t      usb_pad_2,
	input  pad_pkg::pad_word_t      usb_pad_3,
	input  logic                    osd_status,
	input  logic                    ioctl_download,
	output pad_pkg::pad_word_t      player_0,
	output pad_pkg::pad_word_t      player_1,
	output pad_pkg::pad_word_t      player_2,
	output pad_pkg::pad_word_t      player_3,
	output pad_pkg::pad_word_t      player_0_raw,
	output logic                    osd_button,
	output logic                    fast_forward
);

	pad_pkg::pad_word_t pad_a;
	pad_pkg::pad_word_t pad_b;
	logic               present_a;
	logic               present_b;
	logic               combo_a;
	logic               combo_b;

	////////////////////////////////////////
	// Serial port decode
	////////////////////////////////////////

	pad_decode decode_0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.llapi_select  (llapi_select),
		.llapi_en      (llapi_en_0),
		.llapi_buttons (llapi_buttons_0),
		.llapi_type    (llapi_type_0),
		.pad           (pad_a),
		.present       (present_a),
		.menu_combo    (combo_a)
	);

	pad_decode decode_1 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.llapi_select  (llapi_select),
		.llapi_en      (llapi_en_1),
		.llapi_buttons (llapi_buttons_1),
		.llapi_type    (llapi_type_1),
		.pad           (pad_b),
		.present       (present_b),
		.menu_combo    (combo_b)
	);

	////////////////////////////////////////
	// Player slots and fast-forward
	////////////////////////////////////////

	slot_assign slot_assign (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pad_a        (pad_a),
		.pad_b        (pad_b),
		.present_a    (present_a),
		.present_b    (present_b),
		.combo_a      (combo_a),
		.combo_b      (combo_b),
		.usb_pad_0    (usb_pad_0),
		.usb_pad_1    (usb_pad_1),
		.usb_pad_2    (usb_pad_2),
		.usb_pad_3    (usb_pad_3),
		.player_0     (player_0),
		.player_1     (player_1),
		.player_2     (player_2),
		.player_3     (player_3),
		.player_0_raw (player_0_raw),
		.osd_button   (osd_button)
	);

	// Blanked word, so a held savestate button also stops fast-forward
	fast_forward_latch #(
		.tap_cycles (tap_cycles)
	) ff_latch (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.player_0       (player_0),
		.osd_status     (osd_status),
		.ioctl_download (ioctl_download),
		.fast_forward   (fast_forward)
	);

endmodule

//--- src/slot_assign.sv
// USB pads are delayed one cycle to meet the decoded serial pads; at most two serial pads shift USB slots
module slot_assign (
	input  logic               clk_sys,
	input  logic               reset,
	input  pad_pkg::pad_word_t pad_a,
	input  pad_pkg::pad_word_t pad_b,
	input  logic               present_a,
	input  logic               present_b,
	input  logic               combo_a,
	input  logic               combo_b,
	input  pad_pkg::pad_word_t usb_pad_0,
	input  pad_pkg::pad_word_t usb_pad_1,
	input  pad_pkg::pad_word_t usb_pad_2,
	input  pad_pkg::pad_word_t usb_pad_3,
	output pad_pkg::pad_word_t player_0,
	output pad_pkg::pad_word_t player_1,
	output pad_pkg::pad_word_t player_2,
	output pad_pkg::pad_word_t player_3,
	output pad_pkg::pad_word_t player_0_raw,
	output logic               osd_button
);

	pad_pkg::pad_word_t usb_d0;
	pad_pkg::pad_word_t usb_d1;
	pad_pkg::pad_word_t usb_d2;
	pad_pkg::pad_word_t usb_d3;
	pad_pkg::pad_word_t slot_0;

	////////////////////////////////////////
	// USB alignment stage
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			usb_d0 <= '0;
			usb_d1 <= '0;
			usb_d2 <= '0;
			usb_d3 <= '0;
		end else begin
			usb_d0 <= usb_pad_0;
			usb_d1 <= usb_pad_1;
			usb_d2 <= usb_pad_2;
			usb_d3 <= usb_pad_3;
		end
	end

	////////////////////////////////////////
	// Slot mapping
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			slot_0     <= '0;
			player_1   <= '0;
			player_2   <= '0;
			player_3   <= '0;
			osd_button <= 1'b0;
		end else begin
			if (present_a && present_b) begin
				slot_0   <= pad_a;
				player_1 <= pad_b;
				player_2 <= usb_d0;
				player_3 <= usb_d1;
			end else if (present_a || present_b) begin
				// First USB pad fills whichever serial slot is empty
				slot_0   <= present_a ? pad_a : usb_d0;
				player_1 <= present_b ? pad_b : usb_d0;
				player_2 <= usb_d1;
				player_3 <= usb_d2;
			end else begin
				slot_0   <= usb_d0;
				player_1 <= usb_d1;
				player_2 <= usb_d2;
				player_3 <= usb_d3;
			end
			osd_button <= combo_a | combo_b;
		end
	end

	// Raw word still carries the savestate hot-key bits
	assign player_0_raw = slot_0;
	assign player_0 = slot_0[pad_pkg::PAD_BIT_SAVESTATE] ? '0 : slot_0;

endmodule
